/* verilog/mt1r1w_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// mt1r1w shared sizes
// Word, row and bank geometry of the 1R1W memory
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package mt1r1w_pkg;

  localparam int DATA_W = 16;

  // Rows per physical bank
  localparam int NUM_ROW = 32;
  localparam int ROW_W   = 5;

  // Virtual banks seen by the address, plus one spare physical bank
  localparam int NUM_VBANK = 2;
  localparam int VBANK_W   = 1;
  localparam int NUM_PBANK = NUM_VBANK + 1;
  localparam int PBANK_W   = 2;

  // Virtual bank in the top bit, row below it
  localparam int ADDR_W = VBANK_W + ROW_W;

  // Last row of the init walk
  localparam logic [ROW_W-1:0] LAST_ROW = ROW_W'(NUM_ROW - 1);

  // Free bank of every row after init
  localparam logic [PBANK_W-1:0] SPARE_PBANK = PBANK_W'(NUM_VBANK);

endpackage

/* verilog/bank_map_table.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bank map table
// Per-row virtual to physical bank map with a free bank;
// steers a conflicting write to the free bank and remaps
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module bank_map_table (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               write,
  input  logic [mt1r1w_pkg::ADDR_W-1:0]      wr_adr,
  input  logic [mt1r1w_pkg::DATA_W-1:0]      din,
  input  logic                               read,
  input  logic [mt1r1w_pkg::ADDR_W-1:0]      rd_adr,
  output logic                               ready,
  output logic                               bank_rd_en,
  output logic [mt1r1w_pkg::PBANK_W-1:0]     bank_rd_sel,
  output logic [mt1r1w_pkg::ROW_W-1:0]       bank_rd_row,
  output logic                               bank_wr_en,
  output logic [mt1r1w_pkg::PBANK_W-1:0]     bank_wr_sel,
  output logic [mt1r1w_pkg::ROW_W-1:0]       bank_wr_row,
  output logic [mt1r1w_pkg::DATA_W-1:0]      bank_wr_data
);

  // Map entry per row: a physical bank per virtual bank, plus the free one
  logic [mt1r1w_pkg::PBANK_W-1:0] map_q  [mt1r1w_pkg::NUM_ROW][mt1r1w_pkg::NUM_VBANK];
  logic [mt1r1w_pkg::PBANK_W-1:0] free_q [mt1r1w_pkg::NUM_ROW];

  logic [mt1r1w_pkg::ROW_W-1:0]   init_cnt;
  logic                           init_last;

  logic [mt1r1w_pkg::VBANK_W-1:0] rd_vbank;
  logic [mt1r1w_pkg::ROW_W-1:0]   rd_row;
  logic [mt1r1w_pkg::VBANK_W-1:0] wr_vbank;
  logic [mt1r1w_pkg::ROW_W-1:0]   wr_row;

  logic [mt1r1w_pkg::PBANK_W-1:0] rd_pbank;
  logic [mt1r1w_pkg::PBANK_W-1:0] wr_home;
  logic [mt1r1w_pkg::PBANK_W-1:0] wr_free;

  logic                           rd_act;
  logic                           wr_act;
  logic                           conflict;

  // Address split
  assign rd_vbank = rd_adr[mt1r1w_pkg::ADDR_W-1 -: mt1r1w_pkg::VBANK_W];
  assign rd_row   = rd_adr[mt1r1w_pkg::ROW_W-1:0];
  assign wr_vbank = wr_adr[mt1r1w_pkg::ADDR_W-1 -: mt1r1w_pkg::VBANK_W];
  assign wr_row   = wr_adr[mt1r1w_pkg::ROW_W-1:0];

  // Commands are dropped until the init walk is done
  assign rd_act = read && ready;
  assign wr_act = write && ready;

  // Lookups see the map as it was before this cycle
  assign rd_pbank = map_q[rd_row][rd_vbank];
  assign wr_home  = map_q[wr_row][wr_vbank];
  assign wr_free  = free_q[wr_row];

  // Write collides with the read on the same bank
  assign conflict = rd_act && wr_act && (wr_home == rd_pbank);

  assign bank_rd_en   = rd_act;
  assign bank_rd_sel  = rd_pbank;
  assign bank_rd_row  = rd_row;

  assign bank_wr_en   = wr_act;
  assign bank_wr_sel  = conflict ? wr_free : wr_home;
  assign bank_wr_row  = wr_row;
  assign bank_wr_data = din;

  assign init_last = (init_cnt == mt1r1w_pkg::LAST_ROW);

  // Init walk over all rows, then ready
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      init_cnt <= '0;
      ready    <= 1'b0;
    end
    else if (!ready)
    begin
      init_cnt <= init_cnt + 1'b1;
      if (init_last)
        ready <= 1'b1;
    end
  end

  // Identity load during init, swap with the free bank on a conflict
  always_ff @(posedge clk)
  begin
    if (!ready)
    begin
      for (int v = 0; v < mt1r1w_pkg::NUM_VBANK; v++)
        map_q[init_cnt][v] <= v[mt1r1w_pkg::PBANK_W-1:0];
      free_q[init_cnt] <= mt1r1w_pkg::SPARE_PBANK;
    end
    else if (conflict)
    begin
      // Old home bank becomes the row's free bank
      map_q[wr_row][wr_vbank] <= wr_free;
      free_q[wr_row]          <= wr_home;
    end
  end

endmodule

/* verilog/pbank_array.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Physical bank array
// Three single-port banks, port steering and read output mux
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module pbank_array (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               bank_rd_en,
  input  logic [mt1r1w_pkg::PBANK_W-1:0]     bank_rd_sel,
  input  logic [mt1r1w_pkg::ROW_W-1:0]       bank_rd_row,
  input  logic                               bank_wr_en,
  input  logic [mt1r1w_pkg::PBANK_W-1:0]     bank_wr_sel,
  input  logic [mt1r1w_pkg::ROW_W-1:0]       bank_wr_row,
  input  logic [mt1r1w_pkg::DATA_W-1:0]      bank_wr_data,
  output logic [mt1r1w_pkg::DATA_W-1:0]      rd_dout,
  output logic                               rd_vld,
  output logic [mt1r1w_pkg::PBANK_W-1:0]     rd_pbank
);

  logic [mt1r1w_pkg::DATA_W-1:0]  bank_dout [mt1r1w_pkg::NUM_PBANK];
  logic [mt1r1w_pkg::PBANK_W-1:0] rd_sel_q;
  logic                           rd_vld_q;

  for (genvar b = 0; b < mt1r1w_pkg::NUM_PBANK; b++)
  begin : g_bank
    logic [mt1r1w_pkg::DATA_W-1:0] mem [mt1r1w_pkg::NUM_ROW];
    logic [mt1r1w_pkg::DATA_W-1:0] dout_q;
    logic [mt1r1w_pkg::ROW_W-1:0]  port_row;
    logic                          rd_hit;
    logic                          wr_hit;

    // Which port owns this bank this cycle
    assign rd_hit = bank_rd_en && (int'(bank_rd_sel) == b);
    assign wr_hit = bank_wr_en && (int'(bank_wr_sel) == b);

    assign port_row = rd_hit ? bank_rd_row : bank_wr_row;

    // Single port, read or write per cycle
    always_ff @(posedge clk)
    begin
      if (rd_hit)
        dout_q <= mem[port_row];
      else if (wr_hit)
        mem[port_row] <= bank_wr_data;
    end

    assign bank_dout[b] = dout_q;
  end

  // Bank select follows the data by one cycle
  always_ff @(posedge clk)
  begin
    if (bank_rd_en)
      rd_sel_q <= bank_rd_sel;
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      rd_vld_q <= 1'b0;
    else
      rd_vld_q <= bank_rd_en;
  end

  // Output mux over the bank read registers
  always_comb
  begin
    rd_dout = '0;
    for (int b = 0; b < mt1r1w_pkg::NUM_PBANK; b++)
    begin
      if (int'(rd_sel_q) == b)
        rd_dout = bank_dout[b];
    end
  end

  assign rd_vld   = rd_vld_q;
  assign rd_pbank = rd_sel_q;

endmodule

/* verilog/mt1r1w_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// mt1r1w top level
// One read and one write per cycle over three 1-port banks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module mt1r1w_top (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               write,
  input  logic [mt1r1w_pkg::ADDR_W-1:0]      wr_adr,
  input  logic [mt1r1w_pkg::DATA_W-1:0]      din,
  input  logic                               read,
  input  logic [mt1r1w_pkg::ADDR_W-1:0]      rd_adr,
  output logic                               ready,
  output logic [mt1r1w_pkg::DATA_W-1:0]      rd_dout,
  output logic                               rd_vld,
  output logic [mt1r1w_pkg::PBANK_W-1:0]     rd_pbank
);

  logic                             bank_rd_en;
  logic [mt1r1w_pkg::PBANK_W-1:0]   bank_rd_sel;
  logic [mt1r1w_pkg::ROW_W-1:0]     bank_rd_row;
  logic                             bank_wr_en;
  logic [mt1r1w_pkg::PBANK_W-1:0]   bank_wr_sel;
  logic [mt1r1w_pkg::ROW_W-1:0]     bank_wr_row;
  logic [mt1r1w_pkg::DATA_W-1:0]    bank_wr_data;

  // Map table arbitrates the banks between the two ports
  bank_map_table u_map (
    .clk          (clk),
    .rst_n        (rst_n),
    .write        (write),
    .wr_adr       (wr_adr),
    .din          (din),
    .read         (read),
    .rd_adr       (rd_adr),
    .ready        (ready),
    .bank_rd_en   (bank_rd_en),
    .bank_rd_sel  (bank_rd_sel),
    .bank_rd_row  (bank_rd_row),
    .bank_wr_en   (bank_wr_en),
    .bank_wr_sel  (bank_wr_sel),
    .bank_wr_row  (bank_wr_row),
    .bank_wr_data (bank_wr_data)
  );

  pbank_array u_banks (
    .clk          (clk),
    .rst_n        (rst_n),
    .bank_rd_en   (bank_rd_en),
    .bank_rd_sel  (bank_rd_sel),
    .bank_rd_row  (bank_rd_row),
    .bank_wr_en   (bank_wr_en),
    .bank_wr_sel  (bank_wr_sel),
    .bank_wr_row  (bank_wr_row),
    .bank_wr_data (bank_wr_data),
    .rd_dout      (rd_dout),
    .rd_vld       (rd_vld),
    .rd_pbank     (rd_pbank)
  );

endmodule

/* testbench/mt1r1w_clkgen.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Clock generator, 100 ns period
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module mt1r1w_clkgen (
  output logic clk
);

  initial
    clk = 1'b0;

  always #50 clk = ~clk;

endmodule

/* testbench/mt1r1w_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// mt1r1w testbench
// Directed and random 1R1W traffic against a data and map model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module mt1r1w_tb;

  localparam int AW  = mt1r1w_pkg::ADDR_W;
  localparam int DW  = mt1r1w_pkg::DATA_W;
  localparam int RW  = mt1r1w_pkg::ROW_W;
  localparam int VW  = mt1r1w_pkg::VBANK_W;
  localparam int PBW = mt1r1w_pkg::PBANK_W;
  localparam int NUM_ADR = mt1r1w_pkg::NUM_VBANK * mt1r1w_pkg::NUM_ROW;

  localparam int RESET_CYCLES  = 5;
  localparam int READY_TIMEOUT = 100;
  localparam int RANDOM_CYCLES = 600;

  logic           clk;
  logic           rst_n;
  logic           write;
  logic [AW-1:0]  wr_adr;
  logic [DW-1:0]  din;
  logic           read;
  logic [AW-1:0]  rd_adr;
  logic           ready;
  logic [DW-1:0]  rd_dout;
  logic           rd_vld;
  logic [PBW-1:0] rd_pbank;

  integer seed;

  // Reference model of contents and map
  logic [DW-1:0]  mem_model  [NUM_ADR];
  logic           known      [NUM_ADR];
  logic [PBW-1:0] map_model  [mt1r1w_pkg::NUM_ROW][mt1r1w_pkg::NUM_VBANK];
  logic [PBW-1:0] free_model [mt1r1w_pkg::NUM_ROW];

  int             init_seen;
  logic           exp_ready;
  logic           exp_vld;
  logic           exp_known;
  logic [DW-1:0]  exp_dout;
  logic [PBW-1:0] exp_pbank;

  int err_ready;
  int err_vld;
  int err_dout;
  int err_pbank;
  int err_timeout;

  mt1r1w_clkgen u_clk (
    .clk (clk)
  );

  mt1r1w_top UUT (
    .clk      (clk),
    .rst_n    (rst_n),
    .write    (write),
    .wr_adr   (wr_adr),
    .din      (din),
    .read     (read),
    .rd_adr   (rd_adr),
    .ready    (ready),
    .rd_dout  (rd_dout),
    .rd_vld   (rd_vld),
    .rd_pbank (rd_pbank)
  );

  // Model follows the commands sampled at each rising edge
  always @(posedge clk)
  begin
    logic [PBW-1:0] rd_bank;
    logic [PBW-1:0] home;
    logic [VW-1:0]  wv;
    logic [RW-1:0]  wrow;
    if (!rst_n)
    begin
      init_seen <= 0;
      exp_ready <= 1'b0;
      exp_vld   <= 1'b0;
      for (int r = 0; r < mt1r1w_pkg::NUM_ROW; r++)
      begin
        for (int v = 0; v < mt1r1w_pkg::NUM_VBANK; v++)
          map_model[r][v] = v[PBW-1:0];
        free_model[r] = mt1r1w_pkg::SPARE_PBANK;
      end
      for (int a = 0; a < NUM_ADR; a++)
        known[a] = 1'b0;
    end
    else
    begin
      if (!exp_ready)
      begin
        init_seen <= init_seen + 1;
        if (init_seen == mt1r1w_pkg::NUM_ROW - 1)
          exp_ready <= 1'b1;
      end
      exp_vld <= read && exp_ready;
      // Read sees the map and data from before this cycle's write
      if (read && exp_ready)
      begin
        rd_bank = map_model[rd_adr[RW-1:0]][rd_adr[AW-1 -: VW]];
        exp_pbank <= rd_bank;
        exp_dout  <= mem_model[rd_adr];
        exp_known <= known[rd_adr];
      end
      if (write && exp_ready)
      begin
        wv   = wr_adr[AW-1 -: VW];
        wrow = wr_adr[RW-1:0];
        home = map_model[wrow][wv];
        // Conflict moves the write to the free bank and swaps the entry
        if (read && (home == rd_bank))
        begin
          map_model[wrow][wv] = free_model[wrow];
          free_model[wrow]    = home;
        end
        mem_model[wr_adr] = din;
        known[wr_adr]     = 1'b1;
      end
    end
  end

  chk_ready: assert property (@(posedge clk) disable iff (!rst_n) ready == exp_ready)
    else
    begin
      err_ready++;
      $display("CHECK FAILED ready: got %h expected %h", $sampled(ready), $sampled(exp_ready));
    end

  chk_vld: assert property (@(posedge clk) disable iff (!rst_n) rd_vld == exp_vld)
    else
    begin
      err_vld++;
      $display("CHECK FAILED rd_vld: got %h expected %h", $sampled(rd_vld), $sampled(exp_vld));
    end

  chk_dout: assert property (@(posedge clk) disable iff (!rst_n)
                             (exp_vld && exp_known) |-> rd_dout == exp_dout)
    else
    begin
      err_dout++;
      $display("CHECK FAILED rd_dout: got %h expected %h",
               $sampled(rd_dout), $sampled(exp_dout));
    end

  chk_pbank: assert property (@(posedge clk) disable iff (!rst_n)
                              exp_vld |-> rd_pbank == exp_pbank)
    else
    begin
      err_pbank++;
      $display("CHECK FAILED rd_pbank: got %h expected %h",
               $sampled(rd_pbank), $sampled(exp_pbank));
    end

  // Word pattern built from the whole address
  function automatic logic [DW-1:0] fill_word(input logic [AW-1:0] a);
    return {4'hc, a, a};
  endfunction

  task automatic drive_cycle(input logic rd_en, input logic [AW-1:0] ra,
                             input logic wr_en, input logic [AW-1:0] wa,
                             input logic [DW-1:0] d);
    @(posedge clk);
    read   <= rd_en;
    rd_adr <= ra;
    write  <= wr_en;
    wr_adr <= wa;
    din    <= d;
  endtask

  task automatic wait_ready(output logic ok);
    int n;
    n = 0;
    while ((ready !== 1'b1) && (n < READY_TIMEOUT))
    begin
      @(negedge clk);
      n++;
    end
    ok = (ready === 1'b1);
    if (!ok)
    begin
      err_timeout++;
      $display("Timeout: ready did not rise within %0d cycles after reset", READY_TIMEOUT);
    end
  endtask

  task automatic finish_run;
    int total;
    total = err_ready + err_vld + err_dout + err_pbank + err_timeout;
    $display("Errors: ready %0d, rd_vld %0d, rd_dout %0d, rd_pbank %0d, timeout %0d, total %0d",
             err_ready, err_vld, err_dout, err_pbank, err_timeout, total);
    if (total == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  endtask

  initial
  begin
    logic [31:0] r;
    logic        ready_ok;
    seed        = 32'h3459_bde9;
    err_ready   = 0;
    err_vld     = 0;
    err_dout    = 0;
    err_pbank   = 0;
    err_timeout = 0;
    rst_n  = 1'b0;
    write  = 1'b0;
    wr_adr = '0;
    din    = '0;
    read   = 1'b0;
    rd_adr = '0;

    repeat (RESET_CYCLES) @(posedge clk);
    // Reads held high through the init walk must not be accepted
    rst_n  <= 1'b1;
    read   <= 1'b1;
    rd_adr <= 6'h15;
    wait_ready(ready_ok);

    if (ready_ok)
    begin
      // Fill every address, then read back without conflicts
      for (int a = 0; a < NUM_ADR; a++)
        drive_cycle(1'b0, '0, 1'b1, a[AW-1:0], fill_word(a[AW-1:0]));
      for (int a = 0; a < NUM_ADR; a++)
        drive_cycle(1'b1, a[AW-1:0], 1'b0, '0, '0);

      // Same virtual bank, different rows, in both virtual banks
      drive_cycle(1'b1, 6'h03, 1'b1, 6'h07, 16'h3333);
      drive_cycle(1'b1, 6'h07, 1'b0, '0, '0);
      drive_cycle(1'b1, 6'h03, 1'b0, '0, '0);
      drive_cycle(1'b1, 6'h25, 1'b1, 6'h2a, 16'h5a5a);
      drive_cycle(1'b1, 6'h2a, 1'b0, '0, '0);

      // Same address in one cycle, then a read of the new data
      drive_cycle(1'b1, 6'h11, 1'b1, 6'h11, 16'h4444);
      drive_cycle(1'b1, 6'h11, 1'b0, '0, '0);

      // Random traffic, often on the write's virtual bank
      for (int i = 0; i < RANDOM_CYCLES; i++)
      begin
        r = $random(seed);
        drive_cycle(r[16] | r[17], r[14] ? {r[5], r[12:8]} : r[13:8],
                    r[18] | r[19], r[5:0], r[31:16]);
      end

      drive_cycle(1'b0, '0, 1'b0, '0, '0);
      drive_cycle(1'b0, '0, 1'b0, '0, '0);
      @(posedge clk);
    end
    finish_run();
  end

endmodule

/* mt1r1w.f */
verilog/mt1r1w_pkg.sv
verilog/bank_map_table.sv
verilog/pbank_array.sv
verilog/mt1r1w_top.sv
testbench/mt1r1w_clkgen.sv
testbench/mt1r1w_tb.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = mt1r1w_tb
FILELIST  = mt1r1w.f
LOG       = sim.log

.PHONY: sim clean

# Build, run, and decide pass or fail from the log
sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -qx "TEST PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
